// ==== bru_defs.svh ====
// branch unit widths and counts

`ifndef BRU_DEFS_SVH
`define BRU_DEFS_SVH

//////////////////////////////////////////////////
// datapath widths

// register data
`define BRU_WORD_WIDTH 32

// word-address pc, byte bits dropped
`define BRU_PC_WIDTH 14

// physical register tag
`define BRU_TAG_WIDTH 6

// rob position
`define BRU_ROB_WIDTH 6

// btb and direction predictor index, low pc bits
`define BRU_BTB_WIDTH 8

// branch offset as encoded
`define BRU_IMM_WIDTH 16

//////////////////////////////////////////////////
// counts

// complete buses snooped for wakeup
`define BRU_NUM_BUSES 3

`endif

// ==== bru_issue_latch.sv ====
// branch execute input latch

`timescale 1ns/1ps

`include "bru_defs.svh"

module bru_issue_latch (
    input  logic                  CLK,
    input  logic                  nRST,
    // from reservation station
    input  logic                  issue_valid,
    input  bru_pkg::operand_sel_t issue_sel_0,
    input  bru_pkg::operand_sel_t issue_sel_1,
    input  bru_pkg::word_t        issue_raw_0,
    input  bru_pkg::word_t        issue_raw_1,
    input  bru_pkg::bru_op_t      issue_op,
    input  bru_pkg::imm_t         issue_imm,
    input  bru_pkg::pc_t          issue_pc,
    input  bru_pkg::pc_t          issue_npc,
    input  bru_pkg::rob_index_t   issue_rob_index,
    // to resolve
    output logic                  ex_valid,
    output bru_pkg::bru_op_t      ex_op,
    output bru_pkg::operand_sel_t ex_sel_0,
    output bru_pkg::operand_sel_t ex_sel_1,
    output bru_pkg::word_t        ex_raw_0,
    output bru_pkg::word_t        ex_raw_1,
    output bru_pkg::pc_t          ex_branch_pc,
    output bru_pkg::pc_t          ex_pc_plus_1,
    output bru_pkg::pc_t          ex_npc,
    output bru_pkg::btb_index_t   ex_btb_index,
    output bru_pkg::rob_index_t   ex_rob_index
);

    // address math done ahead of execute
    bru_pkg::pc_t       pc_plus_1;
    bru_pkg::pc_t       branch_pc;
    bru_pkg::btb_index_t btb_index;

    // word-address pc, so next instruction is +1
    assign pc_plus_1 = issue_pc + bru_pkg::pc_t'(1);

    // offset relative to the next pc, upper imm bits fall off
    assign branch_pc = pc_plus_1 + bru_pkg::pc_t'(issue_imm[`BRU_PC_WIDTH-1:0]);

    // predictor tables indexed by low pc bits
    assign btb_index = issue_pc[`BRU_BTB_WIDTH-1:0];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ex_valid     <= 1'b0;
            ex_op        <= bru_pkg::OP_BEQ;
            ex_sel_0     <= bru_pkg::SEL_BUS0;
            ex_sel_1     <= bru_pkg::SEL_BUS0;
            ex_raw_0     <= '0;
            ex_raw_1     <= '0;
            ex_branch_pc <= '0;
            ex_pc_plus_1 <= '0;
            ex_npc       <= '0;
            ex_btb_index <= '0;
            ex_rob_index <= '0;
        end else begin
            ex_valid     <= issue_valid;
            ex_op        <= issue_op;
            ex_sel_0     <= issue_sel_0;
            ex_sel_1     <= issue_sel_1;
            ex_raw_0     <= issue_raw_0;
            ex_raw_1     <= issue_raw_1;
            ex_branch_pc <= branch_pc;
            ex_pc_plus_1 <= pc_plus_1;
            ex_npc       <= issue_npc;
            ex_btb_index <= btb_index;
            ex_rob_index <= issue_rob_index;
        end
    end

endmodule

// ==== bru_operand_wakeup.sv ====
// operand wakeup matcher

`timescale 1ns/1ps

`include "bru_defs.svh"

module bru_operand_wakeup (
    input  bru_pkg::phys_tag_t    src_tag,
    input  logic                  bus_tag_valid_0,
    input  logic                  bus_tag_valid_1,
    input  logic                  bus_tag_valid_2,
    input  bru_pkg::phys_tag_t    bus_tag_0,
    input  bru_pkg::phys_tag_t    bus_tag_1,
    input  bru_pkg::phys_tag_t    bus_tag_2,
    output logic                  hit,
    output bru_pkg::operand_sel_t sel
);

    // one valid-tag-match bit per complete bus
    logic [`BRU_NUM_BUSES-1:0] match;

    assign match[0] = bus_tag_valid_0 & (bus_tag_0 == src_tag);
    assign match[1] = bus_tag_valid_1 & (bus_tag_1 == src_tag);
    assign match[2] = bus_tag_valid_2 & (bus_tag_2 == src_tag);

    // any bus broadcasting this tag
    assign hit = |match;

    // lowest bus wins
    // no hit falls back to raw
    always_comb begin
        if (match[0]) begin
            sel = bru_pkg::SEL_BUS0;
        end else if (match[1]) begin
            sel = bru_pkg::SEL_BUS1;
        end else if (match[2]) begin
            sel = bru_pkg::SEL_BUS2;
        end else begin
            sel = bru_pkg::SEL_RAW;
        end
    end

endmodule

// ==== bru_pkg.sv ====
// branch unit shared types

`include "bru_defs.svh"

package bru_pkg;

    //////////////////////////////////////////////////
    // scalar types

    // register file word
    typedef logic [`BRU_WORD_WIDTH-1:0] word_t;

    // word-address pc
    typedef logic [`BRU_PC_WIDTH-1:0] pc_t;

    // physical register tag
    typedef logic [`BRU_TAG_WIDTH-1:0] phys_tag_t;

    // rob slot
    typedef logic [`BRU_ROB_WIDTH-1:0] rob_index_t;

    // predictor table index
    typedef logic [`BRU_BTB_WIDTH-1:0] btb_index_t;

    // branch immediate
    typedef logic [`BRU_IMM_WIDTH-1:0] imm_t;

    //////////////////////////////////////////////////
    // encodings

    // resolved ops
    typedef enum logic [1:0] {
        OP_BEQ = 2'd0,
        OP_BNE = 2'd1,
        OP_JR  = 2'd2
    } bru_op_t;

    // where an execute operand comes from
    // bus data arrives one cycle after its tag
    typedef enum logic [1:0] {
        SEL_BUS0 = 2'd0,
        SEL_BUS1 = 2'd1,
        SEL_BUS2 = 2'd2,
        SEL_RAW  = 2'd3
    } operand_sel_t;

endpackage

// ==== bru_resolve.sv ====
// branch resolution

`timescale 1ns/1ps

`include "bru_defs.svh"

module bru_resolve (
    // from execute latch
    input  logic                  ex_valid,
    input  bru_pkg::bru_op_t      ex_op,
    input  bru_pkg::operand_sel_t ex_sel_0,
    input  bru_pkg::operand_sel_t ex_sel_1,
    input  bru_pkg::word_t        ex_raw_0,
    input  bru_pkg::word_t        ex_raw_1,
    input  bru_pkg::pc_t          ex_branch_pc,
    input  bru_pkg::pc_t          ex_pc_plus_1,
    input  bru_pkg::pc_t          ex_npc,
    input  bru_pkg::btb_index_t   ex_btb_index,
    input  bru_pkg::rob_index_t   ex_rob_index,
    // forwarded complete bus data
    input  bru_pkg::word_t        bus_data_0,
    input  bru_pkg::word_t        bus_data_1,
    input  bru_pkg::word_t        bus_data_2,
    // to rob
    output logic                  complete_valid,
    output logic                  restart_valid,
    output bru_pkg::rob_index_t   restart_rob_index,
    output bru_pkg::pc_t          restart_pc,
    // to fetch predictors
    output logic                  btb_update,
    output bru_pkg::btb_index_t   btb_index,
    output bru_pkg::pc_t          btb_target,
    output logic                  dirp_taken
);

    // resolved operands
    bru_pkg::word_t op_a;
    bru_pkg::word_t op_b;

    // resolved next pc
    bru_pkg::pc_t target;

    //////////////////////////////////////////////////
    // operand forwarding

    always_comb begin
        case (ex_sel_0)
            bru_pkg::SEL_BUS0: op_a = bus_data_0;
            bru_pkg::SEL_BUS1: op_a = bus_data_1;
            bru_pkg::SEL_BUS2: op_a = bus_data_2;
            default:           op_a = ex_raw_0;
        endcase
        case (ex_sel_1)
            bru_pkg::SEL_BUS0: op_b = bus_data_0;
            bru_pkg::SEL_BUS1: op_b = bus_data_1;
            bru_pkg::SEL_BUS2: op_b = bus_data_2;
            default:           op_b = ex_raw_1;
        endcase
    end

    //////////////////////////////////////////////////
    // resolution

    always_comb begin
        dirp_taken = 1'b0;
        btb_update = 1'b0;
        target     = ex_pc_plus_1;
        case (ex_op)
            bru_pkg::OP_BEQ: begin
                dirp_taken = (op_a == op_b);
                btb_update = ex_valid;
                target     = dirp_taken ? ex_branch_pc : ex_pc_plus_1;
            end
            bru_pkg::OP_BNE: begin
                dirp_taken = (op_a != op_b);
                btb_update = ex_valid;
                target     = dirp_taken ? ex_branch_pc : ex_pc_plus_1;
            end
            bru_pkg::OP_JR: begin
                // byte address in register, drop the two byte bits
                target = op_a[`BRU_PC_WIDTH+1:2];
            end
            default: begin
                target = ex_pc_plus_1;
            end
        endcase
    end

    assign complete_valid    = ex_valid;
    // mispredict when fetch went anywhere but the target
    assign restart_valid     = ex_valid & (ex_npc != target);
    assign restart_rob_index = ex_rob_index;
    assign restart_pc        = target;
    assign btb_index         = ex_btb_index;
    assign btb_target        = ex_branch_pc;

endmodule

// ==== bru_rs_stage.sv ====
// branch reservation station stage

`timescale 1ns/1ps

module bru_rs_stage (
    input  logic                  CLK,
    input  logic                  nRST,
    // dispatch
    input  logic                  dispatch_valid,
    input  bru_pkg::bru_op_t      dispatch_op,
    input  logic                  dispatch_src0_needed,
    input  logic                  dispatch_src0_ready,
    input  bru_pkg::phys_tag_t    dispatch_src0_tag,
    input  logic                  dispatch_src1_needed,
    input  logic                  dispatch_src1_ready,
    input  bru_pkg::phys_tag_t    dispatch_src1_tag,
    input  bru_pkg::imm_t         dispatch_imm,
    input  bru_pkg::pc_t          dispatch_pc,
    input  bru_pkg::pc_t          dispatch_npc,
    input  bru_pkg::rob_index_t   dispatch_rob_index,
    output logic                  rs_full,
    // register file read
    output logic                  read_req_valid,
    output bru_pkg::phys_tag_t    read_tag_0,
    output bru_pkg::phys_tag_t    read_tag_1,
    input  logic                  read_serviced,
    input  bru_pkg::word_t        read_data_0,
    input  bru_pkg::word_t        read_data_1,
    // kill
    input  logic                  kill_valid,
    input  bru_pkg::rob_index_t   kill_rob_index,
    // complete bus tags
    input  logic                  bus_tag_valid_0,
    input  logic                  bus_tag_valid_1,
    input  logic                  bus_tag_valid_2,
    input  bru_pkg::phys_tag_t    bus_tag_0,
    input  bru_pkg::phys_tag_t    bus_tag_1,
    input  bru_pkg::phys_tag_t    bus_tag_2,
    // issue to execute latch
    output logic                  issue_valid,
    output bru_pkg::operand_sel_t issue_sel_0,
    output bru_pkg::operand_sel_t issue_sel_1,
    output bru_pkg::word_t        issue_raw_0,
    output bru_pkg::word_t        issue_raw_1,
    output bru_pkg::bru_op_t      issue_op,
    output bru_pkg::imm_t         issue_imm,
    output bru_pkg::pc_t          issue_pc,
    output bru_pkg::pc_t          issue_npc,
    output bru_pkg::rob_index_t   issue_rob_index
);

    // entry control
    logic rs_valid;
    logic src0_ready;
    logic src1_ready;

    // entry payload
    logic                src0_needed;
    logic                src1_needed;
    bru_pkg::phys_tag_t  src0_tag;
    bru_pkg::phys_tag_t  src1_tag;

    // wakeup results
    logic                  hit_0;
    logic                  hit_1;
    bru_pkg::operand_sel_t wake_sel_0;
    bru_pkg::operand_sel_t wake_sel_1;

    // issue decision terms
    logic killed;
    logic src0_avail;
    logic src1_avail;
    logic need_read;

    bru_operand_wakeup u_wakeup_0 (
        .src_tag(src0_tag), .bus_tag_valid_0(bus_tag_valid_0),
        .bus_tag_valid_1(bus_tag_valid_1), .bus_tag_valid_2(bus_tag_valid_2),
        .bus_tag_0(bus_tag_0), .bus_tag_1(bus_tag_1), .bus_tag_2(bus_tag_2),
        .hit(hit_0), .sel(wake_sel_0)
    );

    bru_operand_wakeup u_wakeup_1 (
        .src_tag(src1_tag), .bus_tag_valid_0(bus_tag_valid_0),
        .bus_tag_valid_1(bus_tag_valid_1), .bus_tag_valid_2(bus_tag_valid_2),
        .bus_tag_0(bus_tag_0), .bus_tag_1(bus_tag_1), .bus_tag_2(bus_tag_2),
        .hit(hit_1), .sel(wake_sel_1)
    );

    //////////////////////////////////////////////////
    // issue decision

    // kill only bites while the task waits here
    assign killed = rs_valid & kill_valid & (issue_rob_index == kill_rob_index);

    // operand usable this cycle, from regfile or bus
    assign src0_avail = ~src0_needed | src0_ready | hit_0;
    assign src1_avail = ~src1_needed | src1_ready | hit_1;

    // any ready source goes through the regfile port
    assign need_read = (src0_needed & src0_ready) | (src1_needed & src1_ready);

    assign read_req_valid = rs_valid & ~killed & src0_avail & src1_avail & need_read;
    assign issue_valid    = rs_valid & ~killed & src0_avail & src1_avail
                          & (~need_read | read_serviced);
    assign rs_full        = rs_valid & ~issue_valid & ~killed;

    assign read_tag_0 = src0_tag;
    assign read_tag_1 = src1_tag;

    // ready or unneeded operand takes the raw read data
    assign issue_sel_0 = (~src0_needed | src0_ready) ? bru_pkg::SEL_RAW : wake_sel_0;
    assign issue_sel_1 = (~src1_needed | src1_ready) ? bru_pkg::SEL_RAW : wake_sel_1;
    assign issue_raw_0 = read_data_0;
    assign issue_raw_1 = read_data_1;

    //////////////////////////////////////////////////
    // entry state

    // new task may land the same cycle the old one leaves
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rs_valid   <= 1'b0;
            src0_ready <= 1'b0;
            src1_ready <= 1'b0;
        end else if (dispatch_valid) begin
            rs_valid   <= 1'b1;
            src0_ready <= dispatch_src0_ready;
            src1_ready <= dispatch_src1_ready;
        end else begin
            rs_valid   <= rs_full;
            // stalled wakeup remembered, data read later from regfile
            src0_ready <= src0_ready | (src0_needed & hit_0);
            src1_ready <= src1_ready | (src1_needed & hit_1);
        end
    end

    always_ff @(posedge CLK) begin
        if (dispatch_valid) begin
            issue_op        <= dispatch_op;
            src0_needed     <= dispatch_src0_needed;
            src0_tag        <= dispatch_src0_tag;
            src1_needed     <= dispatch_src1_needed;
            src1_tag        <= dispatch_src1_tag;
            issue_imm       <= dispatch_imm;
            issue_pc        <= dispatch_pc;
            issue_npc       <= dispatch_npc;
            issue_rob_index <= dispatch_rob_index;
        end
    end

endmodule

// ==== bru_top.sv ====
// branch resolution pipeline

`timescale 1ns/1ps

module bru_top (
    input  logic                CLK,
    input  logic                nRST,
    // dispatch
    input  logic                dispatch_valid,
    input  bru_pkg::bru_op_t    dispatch_op,
    input  logic                dispatch_src0_needed,
    input  logic                dispatch_src0_ready,
    input  bru_pkg::phys_tag_t  dispatch_src0_tag,
    input  logic                dispatch_src1_needed,
    input  logic                dispatch_src1_ready,
    input  bru_pkg::phys_tag_t  dispatch_src1_tag,
    input  bru_pkg::imm_t       dispatch_imm,
    input  bru_pkg::pc_t        dispatch_pc,
    input  bru_pkg::pc_t        dispatch_npc,
    input  bru_pkg::rob_index_t dispatch_rob_index,
    output logic                rs_full,
    // register file read
    output logic                read_req_valid,
    output bru_pkg::phys_tag_t  read_tag_0,
    output bru_pkg::phys_tag_t  read_tag_1,
    input  logic                read_serviced,
    input  bru_pkg::word_t      read_data_0,
    input  bru_pkg::word_t      read_data_1,
    // kill
    input  logic                kill_valid,
    input  bru_pkg::rob_index_t kill_rob_index,
    // complete buses
    input  logic                bus_tag_valid_0,
    input  bru_pkg::phys_tag_t  bus_tag_0,
    input  bru_pkg::word_t      bus_data_0,
    input  logic                bus_tag_valid_1,
    input  bru_pkg::phys_tag_t  bus_tag_1,
    input  bru_pkg::word_t      bus_data_1,
    input  logic                bus_tag_valid_2,
    input  bru_pkg::phys_tag_t  bus_tag_2,
    input  bru_pkg::word_t      bus_data_2,
    // resolution
    output logic                complete_valid,
    output logic                restart_valid,
    output bru_pkg::rob_index_t restart_rob_index,
    output bru_pkg::pc_t        restart_pc,
    output logic                btb_update,
    output bru_pkg::btb_index_t btb_index,
    output bru_pkg::pc_t        btb_target,
    output logic                dirp_taken
);

    //////////////////////////////////////////////////
    // rs to execute latch

    logic                  issue_valid;
    bru_pkg::operand_sel_t issue_sel_0, issue_sel_1;
    bru_pkg::word_t        issue_raw_0, issue_raw_1;
    bru_pkg::bru_op_t      issue_op;
    bru_pkg::imm_t         issue_imm;
    bru_pkg::pc_t          issue_pc, issue_npc;
    bru_pkg::rob_index_t   issue_rob_index;

    // execute latch to resolve
    logic                  ex_valid;
    bru_pkg::bru_op_t      ex_op;
    bru_pkg::operand_sel_t ex_sel_0, ex_sel_1;
    bru_pkg::word_t        ex_raw_0, ex_raw_1;
    bru_pkg::pc_t          ex_branch_pc, ex_pc_plus_1, ex_npc;
    bru_pkg::btb_index_t   ex_btb_index;
    bru_pkg::rob_index_t   ex_rob_index;

    bru_rs_stage u_rs_stage (.*);

    bru_issue_latch u_issue_latch (.*);

    bru_resolve u_resolve (.*);

endmodule

// ==== files.f ====
+incdir+.
bru_pkg.sv
bru_operand_wakeup.sv
bru_rs_stage.sv
bru_issue_latch.sv
bru_resolve.sv
bru_top.sv
tb_bru_top.sv

// ==== tb_bru_cases.svh ====
// branch unit test table

`ifndef TB_BRU_CASES_SVH
`define TB_BRU_CASES_SVH

// columns are op, pc, npc, imm, rob, src0 mode, tag0, val0, src1 mode, tag1, val1,
// stall, kill, random, exp complete, exp restart, exp restart pc, exp taken
// src mode 0..2 woken by that bus, 3 ready in regfile, 4 not needed
task automatic load_table();
    add_row("beq_taken_hit", {bru_pkg::OP_BEQ, 14'h0100, 14'h0111, 16'h0010, 6'h01,
        3'd3, 6'h01, 32'h1234_5678, 3'd3, 6'h02, 32'h1234_5678,
        4'd0, 1'b0, 1'b0, 1'b1, 1'b0, 14'h0111, 1'b1});
    add_row("beq_fall_mispredict", {bru_pkg::OP_BEQ, 14'h0200, 14'h0221, 16'h0020, 6'h02,
        3'd3, 6'h03, 32'h0000_0001, 3'd3, 6'h04, 32'h0000_0002,
        4'd0, 1'b0, 1'b0, 1'b1, 1'b1, 14'h0201, 1'b0});
    // negative offset wraps in the 14-bit pc
    add_row("bne_back_mispredict", {bru_pkg::OP_BNE, 14'h0300, 14'h0301, 16'hfffc, 6'h03,
        3'd3, 6'h05, 32'h0000_0005, 3'd3, 6'h06, 32'h0000_0006,
        4'd0, 1'b0, 1'b0, 1'b1, 1'b1, 14'h02fd, 1'b1});
    add_row("bne_stall_three", {bru_pkg::OP_BNE, 14'h0400, 14'h0401, 16'h0008, 6'h04,
        3'd3, 6'h07, 32'hcafe_f00d, 3'd3, 6'h08, 32'hcafe_f00d,
        4'd3, 1'b0, 1'b0, 1'b1, 1'b0, 14'h0401, 1'b0});
    add_row("jr_hit", {bru_pkg::OP_JR, 14'h05a7, 14'h0690, 16'h0000, 6'h05,
        3'd3, 6'h09, 32'h0000_1a40, 3'd4, 6'h0a, 32'h0000_0000,
        4'd0, 1'b0, 1'b0, 1'b1, 1'b0, 14'h0690, 1'b0});
    // top target bit comes from operand bit 15
    add_row("jr_stall_mispredict", {bru_pkg::OP_JR, 14'h0600, 14'h0601, 16'h0000, 6'h06,
        3'd3, 6'h0b, 32'hffff_8004, 3'd4, 6'h0c, 32'h0000_0000,
        4'd1, 1'b0, 1'b0, 1'b1, 1'b1, 14'h2001, 1'b0});
    add_row("beq_wake_bus1", {bru_pkg::OP_BEQ, 14'h0700, 14'h0701, 16'h0004, 6'h07,
        3'd1, 6'h11, 32'h0000_0077, 3'd3, 6'h12, 32'h0000_0077,
        4'd0, 1'b0, 1'b0, 1'b1, 1'b1, 14'h0705, 1'b1});
    add_row("bne_wake_bus2_bus0", {bru_pkg::OP_BNE, 14'h0800, 14'h0811, 16'h0010, 6'h08,
        3'd2, 6'h21, 32'h0000_000a, 3'd0, 6'h22, 32'h0000_000a,
        4'd0, 1'b0, 1'b0, 1'b1, 1'b1, 14'h0801, 1'b0});
    add_row("jr_wake_bus0", {bru_pkg::OP_JR, 14'h0933, 14'h0301, 16'h0000, 6'h09,
        3'd0, 6'h23, 32'h0000_0c04, 3'd4, 6'h24, 32'h0000_0000,
        4'd0, 1'b0, 1'b0, 1'b1, 1'b0, 14'h0301, 1'b0});
    // kill lands in the cycle the stall ends
    add_row("kill_waiting", {bru_pkg::OP_BEQ, 14'h0a00, 14'h0a01, 16'h0000, 6'h2a,
        3'd3, 6'h25, 32'h0000_0001, 3'd3, 6'h26, 32'h0000_0001,
        4'd5, 1'b1, 1'b0, 1'b0, 1'b0, 14'h0000, 1'b0});
    // operands, stall and expected values filled at run time
    add_row("beq_random", {bru_pkg::OP_BEQ, 14'h0b3c, 14'h0b7d, 16'h0040, 6'h0b,
        3'd3, 6'h27, 32'h0000_0000, 3'd3, 6'h28, 32'h0000_0000,
        4'd0, 1'b0, 1'b1, 1'b0, 1'b0, 14'h0000, 1'b0});
    add_row("bne_random", {bru_pkg::OP_BNE, 14'h0cd5, 14'h0cd6, 16'h3000, 6'h0c,
        3'd3, 6'h29, 32'h0000_0000, 3'd3, 6'h2a, 32'h0000_0000,
        4'd0, 1'b0, 1'b1, 1'b0, 1'b0, 14'h0000, 1'b0});
endtask

`endif

// ==== tb_bru_top.sv ====
// branch pipeline testbench

`timescale 1ns/1ps

`include "bru_defs.svh"

module tb_bru_top;

    //////////////////////////////////////////////////
    // table row layout

    typedef struct packed {
        bru_pkg::bru_op_t    op;
        bru_pkg::pc_t        pc;
        bru_pkg::pc_t        npc;
        bru_pkg::imm_t       imm;
        bru_pkg::rob_index_t rob;
        logic [2:0]          src0;
        bru_pkg::phys_tag_t  tag0;
        bru_pkg::word_t      val0;
        logic [2:0]          src1;
        bru_pkg::phys_tag_t  tag1;
        bru_pkg::word_t      val1;
        logic [3:0]          stall;
        logic                kill;
        logic                rnd;
        logic                exp_complete;
        logic                exp_restart;
        bru_pkg::pc_t        exp_pc;
        logic                exp_taken;
    } row_t;

    // dut inputs
    logic CLK, nRST;
    logic dispatch_valid, dispatch_src0_needed, dispatch_src0_ready;
    logic dispatch_src1_needed, dispatch_src1_ready;
    logic read_serviced, kill_valid;
    logic bus_tag_valid_0, bus_tag_valid_1, bus_tag_valid_2;
    bru_pkg::bru_op_t    dispatch_op;
    bru_pkg::phys_tag_t  dispatch_src0_tag, dispatch_src1_tag;
    bru_pkg::phys_tag_t  bus_tag_0, bus_tag_1, bus_tag_2;
    bru_pkg::imm_t       dispatch_imm;
    bru_pkg::pc_t        dispatch_pc, dispatch_npc;
    bru_pkg::rob_index_t dispatch_rob_index, kill_rob_index;
    bru_pkg::word_t      read_data_0, read_data_1;
    bru_pkg::word_t      bus_data_0, bus_data_1, bus_data_2;

    // dut outputs
    logic rs_full, read_req_valid, complete_valid, restart_valid, btb_update, dirp_taken;
    bru_pkg::phys_tag_t  read_tag_0, read_tag_1;
    bru_pkg::rob_index_t restart_rob_index;
    bru_pkg::pc_t        restart_pc, btb_target;
    bru_pkg::btb_index_t btb_index;

    // table, current row name, run limit
    row_t  rows [$];
    string names [$];
    string cur_name;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    // regfile model answers in the same cycle
    bru_pkg::word_t regs [64];
    assign read_data_0 = regs[read_tag_0];
    assign read_data_1 = regs[read_tag_1];

    bru_top u_bru_top (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    //////////////////////////////////////////////////
    // reporting

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("mismatch %s %s: expected %0b actual %0b",
                cur_name, what, exp, act));
        end
    endtask

    task automatic check_pc(input string what, input bru_pkg::pc_t exp,
                            input bru_pkg::pc_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("mismatch %s %s: expected %h actual %h",
                cur_name, what, exp, act));
        end
    endtask

    task automatic check_rob(input string what, input bru_pkg::rob_index_t exp,
                             input bru_pkg::rob_index_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("mismatch %s %s: expected %h actual %h",
                cur_name, what, exp, act));
        end
    endtask

    task automatic check_btb(input string what, input bru_pkg::btb_index_t exp,
                             input bru_pkg::btb_index_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("mismatch %s %s: expected %h actual %h",
                cur_name, what, exp, act));
        end
    endtask

    // run limit counts reset cycles too
    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            stop_on_error("timeout, the pipeline never completed a task");
        end
    end

    //////////////////////////////////////////////////
    // table helpers

    task automatic add_row(input string name, input row_t r);
        names.push_back(name);
        rows.push_back(r);
    endtask

    `include "tb_bru_cases.svh"

    // taken target is offset from the next pc
    function automatic bru_pkg::pc_t branch_pc(input bru_pkg::pc_t pc,
                                               input bru_pkg::imm_t imm);
        return pc + 14'd1 + imm[`BRU_PC_WIDTH-1:0];
    endfunction

    // random operands are equal half the time
    function automatic row_t randomize_row(input row_t r);
        row_t o;
        logic taken;
        o = r;
        o.val0 = $urandom;
        o.val1 = ($urandom % 2) ? o.val0 : $urandom;
        o.stall = $urandom % 3;
        taken = (o.op == bru_pkg::OP_BEQ) ? (o.val0 == o.val1) : (o.val0 != o.val1);
        o.exp_complete = 1'b1;
        o.exp_taken = taken;
        o.exp_pc = taken ? branch_pc(o.pc, o.imm) : bru_pkg::pc_t'(o.pc + 14'd1);
        o.exp_restart = (o.exp_pc != o.npc);
        return o;
    endfunction

    //////////////////////////////////////////////////
    // stimulus

    // tag in cycle 1 and data on the same bus in cycle 2
    task automatic drive_buses(input row_t r, input int cyc);
        logic [2:0] tv;
        bru_pkg::phys_tag_t [2:0] tg;
        bru_pkg::word_t [2:0] dt;
        int b;
        for (b = 0; b < 3; b++) begin
            tv[b] = 1'b0;
            tg[b] = '0;
            // junk on idle buses
            dt[b] = 32'h5a5a_0000 ^ (cyc << 4) ^ b;
            if (r.src0 == b) begin
                tv[b] = (cyc == 1);
                tg[b] = r.tag0;
                if (cyc == 2) dt[b] = r.val0;
            end
            if (r.src1 == b) begin
                tv[b] = (cyc == 1);
                tg[b] = r.tag1;
                if (cyc == 2) dt[b] = r.val1;
            end
        end
        bus_tag_valid_0 <= tv[0];
        bus_tag_valid_1 <= tv[1];
        bus_tag_valid_2 <= tv[2];
        bus_tag_0 <= tg[0];
        bus_tag_1 <= tg[1];
        bus_tag_2 <= tg[2];
        bus_data_0 <= dt[0];
        bus_data_1 <= dt[1];
        bus_data_2 <= dt[2];
    endtask

    // one task from dispatch to completion or kill
    task automatic run_row(input string name, input row_t r);
        int cyc;
        logic done;
        logic exp_done;
        logic exp_read;
        cur_name = name;
        @(posedge CLK);
        if (r.src0 == 3'd3) regs[r.tag0] <= r.val0;
        if (r.src1 == 3'd3) regs[r.tag1] <= r.val1;
        dispatch_valid <= 1'b1;
        dispatch_op <= r.op;
        dispatch_src0_needed <= (r.src0 != 3'd4);
        dispatch_src0_ready <= (r.src0 == 3'd3);
        dispatch_src0_tag <= r.tag0;
        dispatch_src1_needed <= (r.src1 != 3'd4);
        dispatch_src1_ready <= (r.src1 == 3'd3);
        dispatch_src1_tag <= r.tag1;
        dispatch_imm <= r.imm;
        dispatch_pc <= r.pc;
        dispatch_npc <= r.npc;
        dispatch_rob_index <= r.rob;
        @(posedge CLK);
        // task now sits in the rs
        dispatch_valid <= 1'b0;
        cyc = 1;
        done = 1'b0;
        while (!done) begin
            read_serviced <= (cyc > r.stall);
            // kill pulse in the would-be issue cycle
            // other rows send it to a different rob slot
            kill_valid <= (cyc == r.stall + 1);
            kill_rob_index <= r.kill ? r.rob : (r.rob ^ 6'h20);
            drive_buses(r, cyc);
            @(negedge CLK);
            exp_done = r.exp_complete && (cyc == r.stall + 2);
            // regfile read asked for only while a ready source waits
            exp_read = ((r.src0 == 3'd3) || (r.src1 == 3'd3)) && (cyc <= r.stall + 1)
                     && !(r.kill && (cyc == r.stall + 1));
            check_bit("rs_full", (cyc <= r.stall), rs_full);
            check_bit("read_req_valid", exp_read, read_req_valid);
            check_bit("complete_valid", exp_done, complete_valid);
            check_bit("restart_valid", exp_done && r.exp_restart, restart_valid);
            check_bit("btb_update", exp_done && (r.op != bru_pkg::OP_JR), btb_update);
            if (exp_done) begin
                check_pc("restart_pc", r.exp_pc, restart_pc);
                check_rob("restart_rob_index", r.rob, restart_rob_index);
                check_bit("dirp_taken", r.exp_taken, dirp_taken);
                check_btb("btb_index", r.pc[`BRU_BTB_WIDTH-1:0], btb_index);
                check_pc("btb_target", branch_pc(r.pc, r.imm), btb_target);
            end
            // killed task watched a few cycles for stray results
            done = exp_done || (r.kill && cyc == r.stall + 3);
            if (!done) begin
                @(posedge CLK);
                cyc++;
            end
        end
    endtask

    initial begin
        int unsigned seed_ret;
        int a;
        int i;
        row_t r;
        seed_ret = $urandom(32'h4846_ff42);
        for (a = 0; a < 64; a++) begin
            regs[a] = 32'hc0de_0000 ^ (a * 32'h0101_0101);
        end
        nRST <= 1'b0;
        dispatch_valid <= 1'b0;
        dispatch_op <= bru_pkg::OP_BEQ;
        dispatch_src0_needed <= 1'b0;
        dispatch_src0_ready <= 1'b0;
        dispatch_src0_tag <= '0;
        dispatch_src1_needed <= 1'b0;
        dispatch_src1_ready <= 1'b0;
        dispatch_src1_tag <= '0;
        dispatch_imm <= '0;
        dispatch_pc <= '0;
        dispatch_npc <= '0;
        dispatch_rob_index <= '0;
        read_serviced <= 1'b0;
        kill_valid <= 1'b0;
        kill_rob_index <= '0;
        drive_buses('0, 0);
        load_table();
        cycle_limit = rows.size() * 12 + 10;
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        for (i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (r.rnd) r = randomize_row(r);
            run_row(names[i], r);
        end
        @(posedge CLK);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
